// File: column_move_gen.f
+incdir+src
src/chess_pkg.sv
src/move_pkg.sv
src/move_link_if.sv
src/column_loader.sv
src/square_unit.sv
src/column_collector.sv
src/column_move_gen.sv
verification/column_move_gen_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f column_move_gen.f \
		--top-module column_move_gen_tb -o column_move_gen_sim
	./obj_dir/column_move_gen_sim | tee sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: verification/column_move_gen_tb.sv
`timescale 1ns/1ns
`include "column_defs.svh"

module column_move_gen_tb;
	import chess_pkg::*;
	import move_pkg::*;

	// directed and random runs together size the watchdog
	localparam int NUM_TESTS = 46;

	logic       clk;
	logic       reset;
	logic       start;
	column_t    col_state;
	logic [2:0] xpos;
	color_e     side;
	logic       out_valid;
	move_word_u out_word;
	logic       out_credit;
	logic       busy;

	logic [31:0] lfsr = 32'h302e_de8c;
	move_word_u  exp_q [$];
	int          mismatches = 0;
	int          failures = 0;
	int          trailers_seen = 0;
	int          outstanding = 0;
	// 0 prompt, 1 delayed, 2 mostly withheld
	int          credit_mode = 0;

	column_move_gen u_dut (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.col_state  (col_state),
		.xpos       (xpos),
		.side       (side),
		.out_valid  (out_valid),
		.out_word   (out_word),
		.out_credit (out_credit),
		.busy       (busy)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = {1'b0, s[31:1]};
		if (s[0])
			n = n ^ 32'h8020_0003;
		return n;
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	function automatic piece_t make_piece(input color_e c, input piece_kind_e k);
		piece_t p;
		p.color = c;
		p.kind = k;
		return p;
	endfunction

	// expected words of one file in output order
	function automatic void expect_column(input column_t col, input logic [2:0] file,
			input color_e who);
		piece_t     p;
		piece_t     q;
		move_t      mv;
		trailer_t   tr;
		move_word_u w;
		int         count;
		int         reach;
		int         dir;
		int         t;
		bit         pawn;
		bit         home;
		bit         mine;
		count = 0;
		for (int r = 7; r >= 0; r--) begin
			p = col[3'(r)];
			pawn = p.kind == PAWN;
			home = (who == WHITE) ? (r == 1) : (r == 6);
			mine = p.color == who &&
				(pawn || p.kind == ROOK || p.kind == QUEEN || p.kind == KING);
			if (mine) begin
				for (int d = 0; d < 2; d++) begin
					dir = (d == 0) ? 1 : -1;
					if (pawn)
						reach = ((who == WHITE) == (d == 0)) ? (home ? 2 : 1) : 0;
					else
						reach = (p.kind == KING) ? 1 : 7;
					for (int k = 1; k <= reach; k++) begin
						t = r + k * dir;
						if (t < 0 || t > 7)
							break;
						q = col[3'(t)];
						// own pieces and anything ahead of a pawn block
						if (q.kind != EMPTY && (pawn || q.color == who))
							break;
						mv = '0;
						mv.kind = WORD_MOVE;
						mv.capture = q.kind != EMPTY;
						mv.promote = pawn && t == ((who == WHITE) ? 7 : 0);
						mv.double_step = pawn && k == 2;
						mv.from_file = file;
						mv.from_row = 3'(r);
						mv.to_file = file;
						mv.to_row = 3'(t);
						w.move = mv;
						exp_q.push_back(w);
						count++;
						if (q.kind != EMPTY)
							break;
					end
				end
			end
		end
		tr = '0;
		tr.kind = WORD_TRAILER;
		tr.count = 7'(count);
		tr.file = file;
		w.trailer = tr;
		exp_q.push_back(w);
	endfunction

	task automatic check_move(input move_t got, input move_t want);
		if (got !== want) begin
			mismatches++;
			$display("MISMATCH at %0t: move %h, expected %h (row %0d to %0d)",
				$time, got, want, want.from_row + 1, want.to_row + 1);
		end
	endtask

	task automatic check_trailer(input trailer_t got, input trailer_t want);
		if (got !== want) begin
			mismatches++;
			$display("MISMATCH at %0t: trailer %h, expected count %0d file %0d",
				$time, got, want.count, want.file);
		end
	endtask

	// compares every output word against the queue
	initial begin : monitor
		move_word_u want;
		forever begin
			@(negedge clk);
			if (!reset && out_valid) begin
				outstanding++;
				if (outstanding > `OUT_CREDITS) begin
					failures++;
					$display("more words in flight than output credits at %0t", $time);
				end
				if (exp_q.size() == 0) begin
					failures++;
					$display("output word %h arrived with nothing expected at %0t",
						out_word, $time);
				end else begin
					want = exp_q.pop_front();
					if (want.move.kind == WORD_MOVE) begin
						check_move(out_word.move, want.move);
					end else begin
						check_trailer(out_word.trailer, want.trailer);
						trailers_seen++;
					end
				end
			end
		end
	end

	// consumer hands back one slot per pulse
	initial begin : consumer
		logic [31:0] v;
		logic        give;
		out_credit = 1'b0;
		forever begin
			@(posedge clk);
			#2;
			give = 1'b0;
			if (!reset && outstanding > 0) begin
				if (credit_mode == 0) begin
					give = 1'b1;
				end else if (credit_mode == 1) begin
					take_bits(2, v);
					give = v[1:0] == 2'd0;
				end else begin
					take_bits(4, v);
					give = v[3:0] == 4'd0;
				end
			end
			if (give)
				outstanding--;
			out_credit = give;
		end
	end

	initial begin : watchdog
		repeat (NUM_TESTS * 2000 + 10) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", NUM_TESTS * 2000);
		$display("error counts: mismatches %0d, other %0d", mismatches, failures);
		$display("Errors found");
		$finish;
	end

	// poke sends a second start while busy, which must be ignored
	task automatic run_board(input column_t col, input logic [2:0] file, input color_e who,
			input bit poke);
		int target;
		target = trailers_seen + 1;
		@(posedge clk);
		#1;
		while (busy) begin
			@(posedge clk);
			#1;
		end
		expect_column(col, file, who);
		start = 1'b1;
		col_state = col;
		xpos = file;
		side = who;
		@(posedge clk);
		#1;
		start = 1'b0;
		if (poke) begin
			@(posedge clk);
			#1;
			if (!busy) begin
				failures++;
				$display("busy did not rise after start at %0t", $time);
			end
			start = 1'b1;
			col_state = ~col;
			xpos = ~file;
			side = (who == WHITE) ? BLACK : WHITE;
			@(posedge clk);
			#1;
			start = 1'b0;
		end
		while (trailers_seen < target) begin
			@(posedge clk);
			#1;
		end
		if (busy) begin
			failures++;
			$display("busy still high one cycle after the trailer at %0t", $time);
		end
	endtask

	task automatic run_both_sides(input column_t col, input logic [2:0] file);
		run_board(col, file, WHITE, 1'b0);
		run_board(col, file, BLACK, 1'b0);
	endtask

	task automatic random_run(input logic [2:0] file);
		column_t     col;
		logic [31:0] v;
		logic [31:0] c;
		for (int r = 0; r < 8; r++) begin
			take_bits(4, v);
			take_bits(1, c);
			// roughly half the squares empty
			if (v[3:0] < 4'd7)
				col[3'(r)] = make_piece(color_e'(c[0]), piece_kind_e'(v[2:0]));
			else
				col[3'(r)] = make_piece(color_e'(c[0]), EMPTY);
		end
		take_bits(1, c);
		run_board(col, file, color_e'(c[0]), 1'b0);
	endtask

	initial begin : stimulus
		column_t     col;
		logic [31:0] v;
		reset = 1'b1;
		start = 1'b0;
		col_state = '0;
		xpos = 3'd0;
		side = WHITE;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		// pawn pushes, double steps and promotion
		col = '0;
		col[1] = make_piece(WHITE, PAWN);
		col[6] = make_piece(BLACK, PAWN);
		run_both_sides(col, 3'd2);
		col = '0;
		col[1] = make_piece(WHITE, PAWN);
		col[3] = make_piece(BLACK, ROOK);
		col[5] = make_piece(WHITE, KNIGHT);
		col[6] = make_piece(BLACK, PAWN);
		run_both_sides(col, 3'd4);
		col = '0;
		col[1] = make_piece(BLACK, PAWN);
		col[3] = make_piece(WHITE, PAWN);
		col[6] = make_piece(WHITE, PAWN);
		run_both_sides(col, 3'd7);

		// sliders and kings
		col = '0;
		col[0] = make_piece(WHITE, ROOK);
		col[4] = make_piece(WHITE, QUEEN);
		col[6] = make_piece(BLACK, KING);
		run_both_sides(col, 3'd0);
		col = '0;
		col[0] = make_piece(BLACK, ROOK);
		col[3] = make_piece(WHITE, KING);
		col[7] = make_piece(BLACK, QUEEN);
		run_both_sides(col, 3'd6);

		// nothing to move
		col = '0;
		col[0] = make_piece(BLACK, ROOK);
		col[2] = make_piece(BLACK, KING);
		col[5] = make_piece(BLACK, PAWN);
		run_board(col, 3'd1, WHITE, 1'b0);
		col = '0;
		col[1] = make_piece(WHITE, KNIGHT);
		col[2] = make_piece(BLACK, QUEEN);
		col[4] = make_piece(WHITE, BISHOP);
		col[6] = make_piece(WHITE, KNIGHT);
		run_board(col, 3'd3, WHITE, 1'b0);
		run_board('0, 3'd5, BLACK, 1'b0);

		// slow and stalled consumer
		for (int m = 1; m <= 2; m++) begin
			credit_mode = m;
			for (int i = 0; i < 4; i++) begin
				take_bits(3, v);
				random_run(v[2:0]);
			end
		end
		credit_mode = 0;

		// start during a run is dropped
		col = '0;
		col[0] = make_piece(WHITE, ROOK);
		col[4] = make_piece(WHITE, QUEEN);
		col[6] = make_piece(BLACK, KING);
		run_board(col, 3'd5, WHITE, 1'b1);

		for (int f = 0; f < 8; f++) begin
			for (int i = 0; i < 3; i++)
				random_run(3'(f));
		end

		repeat (5) @(posedge clk);
		if (exp_q.size() != 0) begin
			failures++;
			$display("%0d expected words never arrived", exp_q.size());
		end
		$display("error counts: mismatches %0d, other %0d", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: src/column_move_gen.sv
`timescale 1ns/1ns
`include "column_defs.svh"

module column_move_gen (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  chess_pkg::column_t   col_state,
	input  logic [2:0]           xpos,
	input  chess_pkg::color_e    side,
	output logic                 out_valid,
	output move_pkg::move_word_u out_word,
	input  logic                 out_credit,
	output logic                 busy
);
	import chess_pkg::*;

	column_t    column;
	color_e     mover;
	logic [2:0] file_idx;
	logic       go;
	logic       finished;

	// one link per row
	move_link_if link [`COL_SQUARES] ();

	column_loader u_loader (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.col_state (col_state),
		.xpos      (xpos),
		.side      (side),
		.finished  (finished),
		.busy      (busy),
		.column    (column),
		.file_idx  (file_idx),
		.mover     (mover),
		.go        (go)
	);

	for (genvar i = 0; i < `COL_SQUARES; i++) begin : g_sq
		square_unit #(
			.ROW (i)
		) u_sq (
			.clk      (clk),
			.reset    (reset),
			.column   (column),
			.file_idx (file_idx),
			.mover    (mover),
			.go       (go),
			.link     (link[i])
		);
	end

	column_collector u_collector (
		.clk        (clk),
		.reset      (reset),
		.go         (go),
		.file_idx   (file_idx),
		.links      (link),
		.out_valid  (out_valid),
		.out_word   (out_word),
		.out_credit (out_credit),
		.finished   (finished)
	);

endmodule

// File: src/column_collector.sv
`timescale 1ns/1ns
`include "column_defs.svh"

module column_collector (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 go,
	input  logic [2:0]           file_idx,
	move_link_if.collector       links [`COL_SQUARES],
	output logic                 out_valid,
	output move_pkg::move_word_u out_word,
	input  logic                 out_credit,
	output logic                 finished
);
	import move_pkg::*;

	localparam int SW  = $clog2(`LINK_CREDITS);
	localparam int SCW = $clog2(`LINK_CREDITS + 1);
	localparam int OCW = $clog2(`OUT_CREDITS + 1);

	typedef enum logic [1:0] {C_IDLE, C_DRAIN, C_TRAILER} coll_e;

	coll_e                   cstate;
	logic [2:0]              cur;
	logic [6:0]              move_cnt;
	logic [OCW-1:0]          out_cred;
	logic                    out_avail;
	logic                    pop;
	logic                    advance;
	logic                    send_trailer;
	trailer_t                trailer;
	logic [`COL_SQUARES-1:0] link_valid;
	logic [`COL_SQUARES-1:0] link_done;
	logic [`COL_SQUARES-1:0] credit_q;
	move_t                   link_move [`COL_SQUARES];
	move_t                   slot_mem [`COL_SQUARES][`LINK_CREDITS];
	logic [SW-1:0]           slot_wp [`COL_SQUARES];
	logic [SW-1:0]           slot_rp [`COL_SQUARES];
	logic [SCW-1:0]          slot_cnt [`COL_SQUARES];

	for (genvar i = 0; i < `COL_SQUARES; i++) begin : g_link
		assign link_valid[i] = links[i].valid;
		assign link_move[i] = links[i].move;
		assign link_done[i] = links[i].done;
		assign links[i].credit = credit_q[i];
	end

	// keep one credit back for the word on the wire
	assign out_avail = out_cred > OCW'(out_valid);
	assign pop = cstate == C_DRAIN && slot_cnt[cur] != '0 && out_avail;
	// a done link has nothing left in flight
	assign advance = cstate == C_DRAIN && slot_cnt[cur] == '0 && link_done[cur];
	assign send_trailer = cstate == C_TRAILER && out_avail;

	always_comb begin
		trailer       = '0;
		trailer.kind  = WORD_TRAILER;
		trailer.count = move_cnt;
		trailer.file  = file_idx;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cstate    <= C_IDLE;
			cur       <= '0;
			move_cnt  <= '0;
			out_valid <= 1'b0;
			finished  <= 1'b0;
			credit_q  <= '0;
			out_cred  <= OCW'(`OUT_CREDITS);
			for (int i = 0; i < `COL_SQUARES; i++) begin
				slot_wp[i]  <= '0;
				slot_rp[i]  <= '0;
				slot_cnt[i] <= '0;
			end
		end else begin
			out_valid <= pop || send_trailer;
			finished  <= send_trailer;
			credit_q  <= '0;
			out_cred  <= out_cred - OCW'(out_valid) + OCW'(out_credit);
			for (int i = 0; i < `COL_SQUARES; i++) begin
				if (link_valid[i])
					slot_wp[i] <= slot_wp[i] + 1'b1;
				if (pop && cur == 3'(i))
					slot_rp[i] <= slot_rp[i] + 1'b1;
				slot_cnt[i] <= slot_cnt[i] + SCW'(link_valid[i]) - SCW'(pop && cur == 3'(i));
			end
			if (pop) begin
				credit_q[cur] <= 1'b1;
				move_cnt      <= move_cnt + 7'd1;
			end
			case (cstate)
				C_IDLE: begin
					if (go) begin
						cstate   <= C_DRAIN;
						cur      <= 3'(`COL_SQUARES - 1);
						move_cnt <= '0;
					end
				end
				C_DRAIN: begin
					// row 8 first, row 1 last
					if (advance) begin
						if (cur == 3'd0)
							cstate <= C_TRAILER;
						else
							cur <= cur - 3'd1;
					end
				end
				C_TRAILER: begin
					if (send_trailer)
						cstate <= C_IDLE;
				end
				default: cstate <= C_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `COL_SQUARES; i++) begin
			if (link_valid[i])
				slot_mem[i][slot_wp[i]] <= link_move[i];
		end
		if (pop)
			out_word.move <= slot_mem[cur][slot_rp[cur]];
		else if (send_trailer)
			out_word.trailer <= trailer;
	end

	a_out_has_credit: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> out_cred != '0);

	a_out_credit_bound: assert property (@(posedge clk) disable iff (reset)
		out_cred <= OCW'(`OUT_CREDITS));

endmodule

// File: src/square_unit.sv
`timescale 1ns/1ns
`include "column_defs.svh"

module square_unit #(
	parameter int ROW = 0
) (
	input  logic               clk,
	input  logic               reset,
	input  chess_pkg::column_t column,
	input  logic [2:0]         file_idx,
	input  chess_pkg::color_e  mover,
	input  logic               go,
	move_link_if.square        link
);
	import chess_pkg::*;
	import move_pkg::*;

	localparam int PW = $clog2(`SQ_FIFO_DEPTH);
	localparam int CW = $clog2(`LINK_CREDITS + 1);
	localparam logic [3:0] ROW_UP = 4'(ROW + 1);
	localparam logic [3:0] ROW_DN = 4'(ROW - 1);

	typedef enum logic [1:0] {W_IDLE, W_UP, W_DOWN, W_END} walk_e;

	walk_e         wstate;
	logic [3:0]    tgt;
	logic [2:0]    steps;
	piece_t        me;
	piece_t        tp;
	logic          is_pawn;
	logic          movable;
	logic          goes_up;
	logic          goes_down;
	logic          home;
	logic [2:0]    max_steps;
	logic          walking;
	logic          in_range;
	logic          tgt_empty;
	logic          tgt_enemy;
	logic          emit_want;
	logic          fifo_full;
	logic          stall;
	logic          dir_end;
	logic          wr_en;
	move_t         gen_move;
	move_t         fifo_mem [`SQ_FIFO_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0]   fifo_cnt;
	logic [CW-1:0] credits;

	assign me = column[ROW];
	assign tp = column[tgt[2:0]];
	assign is_pawn = me.kind == PAWN;
	assign movable = me.color == mover &&
		(is_pawn || me.kind == ROOK || me.kind == QUEEN || me.kind == KING);
	// pawns only walk forward
	assign goes_up = movable && !(is_pawn && me.color == BLACK);
	assign goes_down = movable && !(is_pawn && me.color == WHITE);
	assign home = (me.color == WHITE) ? (ROW == 1) : (ROW == 6);

	always_comb begin
		if (is_pawn)
			max_steps = home ? 3'd2 : 3'd1;
		else if (me.kind == KING)
			max_steps = 3'd1;
		else
			max_steps = 3'd7;
	end

	// tgt bit 3 set means off the board
	assign walking = wstate == W_UP || wstate == W_DOWN;
	assign in_range = !tgt[3] && steps < max_steps;
	assign tgt_empty = tp.kind == EMPTY;
	// pawns never take straight ahead
	assign tgt_enemy = !tgt_empty && tp.color != me.color && !is_pawn;
	assign emit_want = walking && in_range && (tgt_empty || tgt_enemy);
	assign fifo_full = fifo_cnt == (PW+1)'(`SQ_FIFO_DEPTH);
	assign stall = emit_want && fifo_full;
	assign wr_en = emit_want && !fifo_full;
	assign dir_end = walking && !stall && (!in_range || !tgt_empty);

	always_comb begin
		gen_move             = '0;
		gen_move.kind        = WORD_MOVE;
		gen_move.capture     = !tgt_empty;
		gen_move.promote     = is_pawn && tgt[2:0] == ((me.color == WHITE) ? 3'd7 : 3'd0);
		gen_move.double_step = is_pawn && steps == 3'd1;
		gen_move.from_file   = file_idx;
		gen_move.from_row    = 3'(ROW);
		gen_move.to_file     = file_idx;
		gen_move.to_row      = tgt[2:0];
	end

	// walker takes the upward pass before the downward one
	always_ff @(posedge clk) begin
		if (reset) begin
			wstate <= W_IDLE;
			tgt    <= '0;
			steps  <= '0;
		end else if (go) begin
			steps <= '0;
			if (goes_up) begin
				wstate <= W_UP;
				tgt    <= ROW_UP;
			end else if (goes_down) begin
				wstate <= W_DOWN;
				tgt    <= ROW_DN;
			end else begin
				wstate <= W_END;
			end
		end else if (dir_end) begin
			steps <= '0;
			if (wstate == W_UP && goes_down) begin
				wstate <= W_DOWN;
				tgt    <= ROW_DN;
			end else begin
				wstate <= W_END;
			end
		end else if (wr_en) begin
			tgt   <= (wstate == W_UP) ? tgt + 4'd1 : tgt - 4'd1;
			steps <= steps + 3'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			fifo_mem[wr_ptr] <= gen_move;
	end

	// link side of the FIFO
	assign link.valid = fifo_cnt != '0 && credits != '0;
	assign link.move = fifo_mem[rd_ptr];
	assign link.done = wstate == W_END && fifo_cnt == '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
			credits  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (link.valid)
				rd_ptr <= rd_ptr + 1'b1;
			fifo_cnt <= fifo_cnt + (PW+1)'(wr_en) - (PW+1)'(link.valid);
			if (go)
				credits <= CW'(`LINK_CREDITS);
			else
				credits <= credits - CW'(link.valid) + CW'(link.credit);
		end
	end

	a_valid_has_credit: assert property (@(posedge clk) disable iff (reset)
		link.valid && credits == CW'(1) && !link.credit |=> !link.valid);

	a_credit_bound: assert property (@(posedge clk) disable iff (reset)
		credits <= CW'(`LINK_CREDITS));

	a_no_write_full: assert property (@(posedge clk) disable iff (reset)
		fifo_cnt <= (PW+1)'(`SQ_FIFO_DEPTH));

endmodule

// File: src/column_loader.sv
`timescale 1ns/1ns

module column_loader (
	input  logic               clk,
	input  logic               reset,
	input  logic               start,
	input  chess_pkg::column_t col_state,
	input  logic [2:0]         xpos,
	input  chess_pkg::color_e  side,
	input  logic               finished,
	output logic               busy,
	output chess_pkg::column_t column,
	output logic [2:0]         file_idx,
	output chess_pkg::color_e  mover,
	output logic               go
);

	logic accept;

	// new boards only between runs
	assign accept = start && !busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			go   <= 1'b0;
		end else begin
			go <= accept;
			if (accept) begin
				busy <= 1'b1;
			end else if (finished) begin
				busy <= 1'b0;
			end
		end
	end

	// board held steady for the whole run
	always_ff @(posedge clk) begin
		if (accept) begin
			column   <= col_state;
			file_idx <= xpos;
			mover    <= side;
		end
	end

endmodule

// File: src/move_link_if.sv
`timescale 1ns/1ns

interface move_link_if;
	import move_pkg::*;

	// square to collector
	logic  valid;
	move_t move;
	logic  done;

	// one slot back per pulse
	logic  credit;

	modport square (
		output valid,
		output move,
		output done,
		input  credit
	);

	modport collector (
		input  valid,
		input  move,
		input  done,
		output credit
	);

endinterface

// File: src/move_pkg.sv
package move_pkg;

	// top bit of every output word
	localparam logic WORD_MOVE    = 1'b0;
	localparam logic WORD_TRAILER = 1'b1;

	// rows and files are zero based
	typedef struct packed {
		logic       kind;
		logic       capture;
		logic       promote;
		logic       double_step;
		logic [2:0] from_file;
		logic [2:0] from_row;
		logic [2:0] to_file;
		logic [2:0] to_row;
	} move_t;

	// closes the move list of one file
	typedef struct packed {
		logic       kind;
		logic [6:0] count;
		logic [2:0] file;
		logic [4:0] pad;
	} trailer_t;

	// kind bit says which view is live
	typedef union packed {
		move_t    move;
		trailer_t trailer;
	} move_word_u;

endpackage

// File: src/chess_pkg.sv
package chess_pkg;

	typedef enum logic {
		WHITE = 1'b0,
		BLACK = 1'b1
	} color_e;

	typedef enum logic [2:0] {
		EMPTY  = 3'd0,
		PAWN   = 3'd1,
		KNIGHT = 3'd2,
		BISHOP = 3'd3,
		ROOK   = 3'd4,
		QUEEN  = 3'd5,
		KING   = 3'd6
	} piece_kind_e;

	// 4-bit square code with color on top
	typedef struct packed {
		color_e      color;
		piece_kind_e kind;
	} piece_t;

	// one board file with row 1 at index 0
	typedef piece_t [7:0] column_t;

endpackage

// File: src/column_defs.svh
`ifndef COLUMN_DEFS_SVH
`define COLUMN_DEFS_SVH

// squares in one board file
`define COL_SQUARES 8

// move entries held by each square unit
`define SQ_FIFO_DEPTH 4

// collector slots reserved per square link
`define LINK_CREDITS 2

// word slots granted by the consumer after reset
`define OUT_CREDITS 4

`endif
